// File: Makefile
# Verilator flow for the reorder buffer

VERILATOR  ?= verilator
TOP        := rob_tb
LINT_TOP   := rob_top
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

# the run passes only if the log holds the pass message
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+tests
verilog/rob_pkg.sv
verilog/isa_pkg.sv
verilog/rob_credit_counter.sv
verilog/rob_entry_table.sv
verilog/rob_result_store.sv
verilog/rob_commit_fsm.sv
verilog/rob_top.sv
tests/rob_tb.sv

// File: tests/rob_tb_table.svh
// one row per instruction, in program order
// columns: class, rd, predicted taken, actual taken, result, jump target, completion delay
task automatic load_table();
    add_row(isa_pkg::op_alu,     5'd1,  1'b0, 1'b0, 32'hd000_0000, 32'h0000_0000, 4);
    add_row(isa_pkg::op_load,    5'd2,  1'b0, 1'b0, 32'hd000_0001, 32'h0000_0000, 9);
    add_row(isa_pkg::op_alu,     5'd3,  1'b0, 1'b0, 32'hd000_0002, 32'h0000_0000, 1);
    add_row(isa_pkg::op_store_w, 5'd0,  1'b0, 1'b0, 32'hd000_0003, 32'h0000_0000, 2);
    add_row(isa_pkg::op_alu,     5'd4,  1'b0, 1'b0, 32'hd000_0004, 32'h0000_0000, 6);
    add_row(isa_pkg::op_load,    5'd5,  1'b0, 1'b0, 32'hd000_0005, 32'h0000_0000, 3);
    // taken and predicted taken, so no flush
    add_row(isa_pkg::op_branch,  5'd0,  1'b1, 1'b1, 32'hd000_0006, 32'h0000_4000, 5);
    add_row(isa_pkg::op_alu,     5'd6,  1'b0, 1'b0, 32'hd000_0007, 32'h0000_0000, 0);
    add_row(isa_pkg::op_store_b, 5'd0,  1'b0, 1'b0, 32'hd000_0008, 32'h0000_0000, 7);
    add_row(isa_pkg::op_alu,     5'd7,  1'b0, 1'b0, 32'hd000_0009, 32'h0000_0000, 2);
    add_row(isa_pkg::op_load,    5'd8,  1'b0, 1'b0, 32'hd000_000a, 32'h0000_0000, 12);
    add_row(isa_pkg::op_alu,     5'd9,  1'b0, 1'b0, 32'hd000_000b, 32'h0000_0000, 1);
    add_row(isa_pkg::op_store_h, 5'd0,  1'b0, 1'b0, 32'hd000_000c, 32'h0000_0000, 3);
    add_row(isa_pkg::op_alu,     5'd10, 1'b0, 1'b0, 32'hd000_000d, 32'h0000_0000, 5);
    add_row(isa_pkg::op_alu,     5'd11, 1'b0, 1'b0, 32'hd000_000e, 32'h0000_0000, 0);
    add_row(isa_pkg::op_load,    5'd12, 1'b0, 1'b0, 32'hd000_000f, 32'h0000_0000, 8);
    // first tag reuse after the wrap
    add_row(isa_pkg::op_alu,     5'd13, 1'b0, 1'b0, 32'hd000_0010, 32'h0000_0000, 2);
    add_row(isa_pkg::op_store_w, 5'd0,  1'b0, 1'b0, 32'hd000_0011, 32'h0000_0000, 4);
    // mispredicted, everything younger gets squashed
    add_row(isa_pkg::op_branch,  5'd14, 1'b0, 1'b1, 32'hd000_0012, 32'h0000_8800, 8);
    add_row(isa_pkg::op_alu,     5'd15, 1'b0, 1'b0, 32'hd000_0013, 32'h0000_0000, 1);
    add_row(isa_pkg::op_load,    5'd16, 1'b0, 1'b0, 32'hd000_0014, 32'h0000_0000, 3);
    add_row(isa_pkg::op_store_w, 5'd0,  1'b0, 1'b0, 32'hd000_0015, 32'h0000_0000, 0);
    add_row(isa_pkg::op_alu,     5'd17, 1'b0, 1'b0, 32'hd000_0016, 32'h0000_0000, 6);
    add_row(isa_pkg::op_alu,     5'd18, 1'b0, 1'b0, 32'hd000_0017, 32'h0000_0000, 2);
    add_row(isa_pkg::op_load,    5'd19, 1'b0, 1'b0, 32'hd000_0018, 32'h0000_0000, 4);
    add_row(isa_pkg::op_alu,     5'd20, 1'b0, 1'b0, 32'hd000_0019, 32'h0000_0000, 1);
    add_row(isa_pkg::op_store_b, 5'd0,  1'b0, 1'b0, 32'hd000_001a, 32'h0000_0000, 5);
    add_row(isa_pkg::op_alu,     5'd21, 1'b0, 1'b0, 32'hd000_001b, 32'h0000_0000, 0);
    add_row(isa_pkg::op_branch,  5'd0,  1'b0, 1'b0, 32'hd000_001c, 32'h0000_9000, 3);
    add_row(isa_pkg::op_alu,     5'd22, 1'b0, 1'b0, 32'hd000_001d, 32'h0000_0000, 7);
    add_row(isa_pkg::op_load,    5'd23, 1'b0, 1'b0, 32'hd000_001e, 32'h0000_0000, 2);
    add_row(isa_pkg::op_alu,     5'd24, 1'b0, 1'b0, 32'hd000_001f, 32'h0000_0000, 1);
    add_row(isa_pkg::op_store_h, 5'd0,  1'b0, 1'b0, 32'hd000_0020, 32'h0000_0000, 4);
    add_row(isa_pkg::op_alu,     5'd25, 1'b0, 1'b0, 32'hd000_0021, 32'h0000_0000, 9);
    add_row(isa_pkg::op_alu,     5'd26, 1'b0, 1'b0, 32'hd000_0022, 32'h0000_0000, 0);
    add_row(isa_pkg::op_load,    5'd27, 1'b0, 1'b0, 32'hd000_0023, 32'h0000_0000, 3);
    add_row(isa_pkg::op_store_w, 5'd0,  1'b0, 1'b0, 32'hd000_0024, 32'h0000_0000, 1);
    add_row(isa_pkg::op_alu,     5'd28, 1'b0, 1'b0, 32'hd000_0025, 32'h0000_0000, 2);
endtask

// File: tests/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rob_tb;

    localparam int n_rows     = 38;
    localparam int max_cycles = 2000;

    logic               clk;
    logic               rst;
    logic               alloc_valid;
    isa_pkg::op_class_t alloc_class;
    rob_pkg::regnm_t    alloc_rd;
    logic               alloc_pred;
    rob_pkg::tag_t      alloc_tag;
    logic               cmpl_valid;
    rob_pkg::tag_t      cmpl_tag;
    rob_pkg::data_t     cmpl_data;
    logic               cmpl_actual;
    rob_pkg::addr_t     cmpl_jump_pc;
    logic               commit_valid;
    rob_pkg::regnm_t    commit_rd;
    rob_pkg::data_t     commit_data;
    rob_pkg::tag_t      commit_tag;
    logic               store_valid;
    rob_pkg::tag_t      store_tag;
    logic               store_done;
    logic               flush;
    rob_pkg::addr_t     redirect_pc;
    logic               credit_valid;

    // stimulus table columns
    isa_pkg::op_class_t row_class [n_rows];
    rob_pkg::regnm_t    row_rd [n_rows];
    logic               row_pred [n_rows];
    logic               row_actual [n_rows];
    rob_pkg::data_t     row_data [n_rows];
    rob_pkg::addr_t     row_jump [n_rows];
    int                 row_delay [n_rows];
    int                 rows_loaded;

    // reference model
    int     inflight [$];
    int     waiting [$];
    int     row_tag [n_rows];
    int     ready_at [n_rows];
    logic   completed [n_rows];
    int     credits;
    int     next_row;
    int     next_tag;
    int     cycle;
    integer seed;
    logic   store_busy;
    int     store_row;
    int     store_timer;
    logic   restart_pending;
    int     restart_seen;

    int errors;
    int commits;
    int stores;
    int flushes;
    int exp_flushes;

    rob_top i_rob_top (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (alloc_valid),
        .alloc_class  (alloc_class),
        .alloc_rd     (alloc_rd),
        .alloc_pred   (alloc_pred),
        .alloc_tag    (alloc_tag),
        .cmpl_valid   (cmpl_valid),
        .cmpl_tag     (cmpl_tag),
        .cmpl_data    (cmpl_data),
        .cmpl_actual  (cmpl_actual),
        .cmpl_jump_pc (cmpl_jump_pc),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_tag   (commit_tag),
        .store_valid  (store_valid),
        .store_tag    (store_tag),
        .store_done   (store_done),
        .flush        (flush),
        .redirect_pc  (redirect_pc),
        .credit_valid (credit_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic add_row(input isa_pkg::op_class_t cls, input rob_pkg::regnm_t rd,
                           input logic pred, input logic act, input rob_pkg::data_t data,
                           input rob_pkg::addr_t jump, input int delay);
        row_class[rows_loaded]  = cls;
        row_rd[rows_loaded]     = rd;
        row_pred[rows_loaded]   = pred;
        row_actual[rows_loaded] = act;
        row_data[rows_loaded]   = data;
        row_jump[rows_loaded]   = jump;
        row_delay[rows_loaded]  = delay;
        completed[rows_loaded]  = 1'b0;
        rows_loaded++;
    endtask

    `include "rob_tb_table.svh"

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        errors++;
    endtask

    // credits, commits and flushes seen in the cycle just ended
    task automatic watch_outputs();
        int row;
        if (credit_valid) begin
            credits++;
            if (credits > rob_pkg::rob_depth) begin
                report_failure("more credits returned than the buffer has entries");
            end
        end
        if (flush) begin
            flushes++;
            if (!commit_valid) begin
                report_failure("flush raised without a commit");
            end
        end
        if (commit_valid) begin
            if (inflight.size() == 0) begin
                report_failure("commit with no entry in flight");
            end else begin
                row = inflight.pop_front();
                commits++;
                if (isa_pkg::is_store_class(row_class[row])) begin
                    report_failure("store at the head retired through commit_valid");
                end
                if (commit_rd !== row_rd[row]) begin
                    report_mismatch("commit_rd", commit_rd, row_rd[row]);
                end
                if (commit_data !== row_data[row]) begin
                    report_mismatch("commit_data", commit_data, row_data[row]);
                end
                if (commit_tag !== rob_pkg::tag_t'(row_tag[row])) begin
                    report_mismatch("commit_tag", commit_tag, row_tag[row]);
                end
                if (flush !== (row_pred[row] != row_actual[row])) begin
                    report_mismatch("flush", flush, row_pred[row] != row_actual[row]);
                end
                if (row_pred[row] != row_actual[row]) begin
                    if (redirect_pc !== row_jump[row]) begin
                        report_mismatch("redirect_pc", redirect_pc, row_jump[row]);
                    end
                    // younger entries are squashed and tags restart
                    inflight.delete();
                    waiting.delete();
                    next_tag = 0;
                    restart_pending = 1'b1;
                end
            end
        end
    endtask

    // store buffer model
    task automatic drive_store();
        if (store_done) begin
            store_done = 1'b0;
            if (store_valid) begin
                report_failure("store_valid still high after store_done");
            end
        end else if (store_busy) begin
            if (!store_valid) begin
                report_failure("store_valid dropped before store_done");
            end
            if (store_timer > 0) begin
                store_timer--;
            end else if (completed[store_row]) begin
                store_done = 1'b1;
                store_busy = 1'b0;
                void'(inflight.pop_front());
                stores++;
            end
        end else if (store_valid) begin
            if (inflight.size() == 0) begin
                report_failure("store_valid with no entry in flight");
            end else begin
                store_row = inflight[0];
                if (!isa_pkg::is_store_class(row_class[store_row])) begin
                    report_failure("store_valid raised for a non-store head");
                end
                if (store_tag !== rob_pkg::tag_t'(row_tag[store_row])) begin
                    report_mismatch("store_tag", store_tag, row_tag[store_row]);
                end
                store_busy  = 1'b1;
                store_timer = $unsigned($random(seed)) % 6;
            end
        end
    endtask

    // one completion per cycle, random pick among the ready rows
    task automatic drive_completion();
        int cand [$];
        int pick;
        int row;
        cmpl_valid = 1'b0;
        foreach (waiting[i]) begin
            if (ready_at[waiting[i]] <= cycle) begin
                cand.push_back(i);
            end
        end
        if (cand.size() > 0) begin
            pick = cand[$unsigned($random(seed)) % cand.size()];
            row  = waiting[pick];
            waiting.delete(pick);
            cmpl_valid   = 1'b1;
            cmpl_tag     = rob_pkg::tag_t'(row_tag[row]);
            cmpl_data    = row_data[row];
            cmpl_actual  = row_actual[row];
            cmpl_jump_pc = row_jump[row];
            completed[row] = 1'b1;
        end
    endtask

    // dispatcher spends one credit per allocation
    task automatic drive_alloc();
        alloc_valid = 1'b0;
        if (next_row < n_rows && credits > 0 && !flush) begin
            if (alloc_tag !== rob_pkg::tag_t'(next_tag)) begin
                report_mismatch("alloc_tag", alloc_tag, next_tag);
            end
            if (restart_pending) begin
                restart_pending = 1'b0;
                restart_seen++;
            end
            alloc_valid = 1'b1;
            alloc_class = row_class[next_row];
            alloc_rd    = row_rd[next_row];
            alloc_pred  = row_pred[next_row];
            row_tag[next_row]  = next_tag;
            ready_at[next_row] = cycle + 1 + row_delay[next_row];
            inflight.push_back(next_row);
            waiting.push_back(next_row);
            credits--;
            next_tag = (next_tag + 1) % rob_pkg::rob_depth;
            next_row++;
        end
    endtask

    initial begin
        rst          = 1'b1;
        alloc_valid  = 1'b0;
        alloc_class  = isa_pkg::op_alu;
        alloc_rd     = '0;
        alloc_pred   = 1'b0;
        cmpl_valid   = 1'b0;
        cmpl_tag     = '0;
        cmpl_data    = '0;
        cmpl_actual  = 1'b0;
        cmpl_jump_pc = '0;
        store_done   = 1'b0;
        seed            = 61384;
        errors          = 0;
        commits         = 0;
        stores          = 0;
        flushes         = 0;
        rows_loaded     = 0;
        credits         = rob_pkg::rob_depth;
        next_row        = 0;
        next_tag        = 0;
        cycle           = 0;
        store_busy      = 1'b0;
        store_row       = 0;
        store_timer     = 0;
        restart_pending = 1'b0;
        restart_seen    = 0;

        load_table();
        if (rows_loaded != n_rows) begin
            report_failure("stimulus table row count does not match n_rows");
        end
        exp_flushes = 0;
        for (int i = 0; i < n_rows; i++) begin
            if (row_pred[i] != row_actual[i]) begin
                exp_flushes++;
            end
        end

        repeat (10) @(negedge clk);
        if (commit_valid || store_valid || flush || credit_valid) begin
            report_failure("output strobe high after reset");
        end
        rst = 1'b0;

        while ((next_row < n_rows || inflight.size() > 0 || store_done ||
                credits != rob_pkg::rob_depth) && cycle < max_cycles) begin
            @(negedge clk);
            cycle++;
            watch_outputs();
            drive_store();
            drive_completion();
            drive_alloc();
        end
        if (cycle >= max_cycles) begin
            report_failure("timed out before the buffer drained and all credits came back");
        end

        // buffer must stay quiet once drained
        repeat (5) begin
            @(negedge clk);
            watch_outputs();
            if (store_valid) begin
                report_failure("store_valid raised with the buffer empty");
            end
        end

        if (flushes != exp_flushes) begin
            report_mismatch("flush count", flushes, exp_flushes);
        end
        if (flushes > 0 && restart_seen == 0) begin
            report_failure("no allocation followed the flush");
        end

        $display("rob_tb: %0d commits, %0d stores, %0d flushes, %0d credits, %0d errors",
                 commits, stores, flushes, credits, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // instruction classes seen by the buffer
    typedef enum logic [2:0] {
        op_alu     = 3'd0,
        op_load    = 3'd1,
        op_store_b = 3'd2,
        op_store_h = 3'd3,
        op_store_w = 3'd4,
        op_branch  = 3'd5
    } op_class_t;

    // stores retire through the store buffer, not the register file
    function automatic logic is_store_class(input op_class_t op);
        logic hit;
        case (op)
            op_store_b,
            op_store_h,
            op_store_w: hit = 1'b1;
            default:    hit = 1'b0;
        endcase
        return hit;
    endfunction

endpackage

`default_nettype wire

// File: verilog/rob_commit_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module rob_commit_fsm (
    input  logic            clk,
    input  logic            rst,
    input  logic            head_valid,
    input  logic            head_done,
    input  logic            head_store,
    input  logic            head_mispredict,
    input  rob_pkg::tag_t   head_tag,
    input  rob_pkg::regnm_t head_rd,
    input  rob_pkg::data_t  head_data,
    input  rob_pkg::addr_t  head_jump_pc,
    input  logic            store_done,
    output logic            retire,
    output logic            clear,
    output logic            commit_valid,
    output rob_pkg::regnm_t commit_rd,
    output rob_pkg::data_t  commit_data,
    output rob_pkg::tag_t   commit_tag,
    output logic            store_valid,
    output rob_pkg::tag_t   store_tag,
    output logic            flush,
    output rob_pkg::addr_t  redirect_pc
);

    rob_pkg::commit_state_t state_q;

    logic idle_wb;

    // head is ready for a write-back
    assign idle_wb = (state_q == rob_pkg::st_idle) && head_valid && head_done && !head_store;

    // mispredicted branch is wiped by clear, not retired
    assign retire = (idle_wb && !head_mispredict) ||
                    ((state_q == rob_pkg::st_store_wait) && store_done);
    assign clear  = (state_q == rob_pkg::st_flush);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= rob_pkg::st_idle;
            commit_valid <= 1'b0;
            store_valid  <= 1'b0;
            flush        <= 1'b0;
        end else begin
            commit_valid <= 1'b0;
            flush        <= 1'b0;
            case (state_q)
                rob_pkg::st_idle: begin
                    if (idle_wb) begin
                        commit_valid <= 1'b1;
                        if (head_mispredict) begin
                            flush   <= 1'b1;
                            state_q <= rob_pkg::st_flush;
                        end
                    end else if (head_valid && head_store) begin
                        store_valid <= 1'b1;
                        state_q     <= rob_pkg::st_store_wait;
                    end
                end
                rob_pkg::st_store_wait: begin
                    if (store_done) begin
                        store_valid <= 1'b0;
                        state_q     <= rob_pkg::st_idle;
                    end
                end
                default: begin
                    state_q <= rob_pkg::st_idle;
                end
            endcase
        end
    end

    // payload captured alongside the strobes
    always_ff @(posedge clk) begin
        if (idle_wb) begin
            commit_rd   <= head_rd;
            commit_data <= head_data;
            commit_tag  <= head_tag;
            redirect_pc <= head_jump_pc;
        end
        if ((state_q == rob_pkg::st_idle) && !idle_wb && head_valid && head_store) begin
            store_tag <= head_tag;
        end
    end

    // no store outstanding or acknowledged while the flush is up
    a_flush_not_store: assert property (
        @(posedge clk) disable iff (rst)
        flush |-> !(store_valid || store_done)
    );

endmodule

`default_nettype wire

// File: verilog/rob_credit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module rob_credit_counter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         free_one,
    input  logic                         free_many,
    input  logic [rob_pkg::credit_w-1:0] free_count,
    output logic                         credit_valid
);

    // freed entries whose credit has not gone back yet
    logic [rob_pkg::credit_w-1:0] pending_q;
    logic [rob_pkg::credit_w-1:0] add;
    logic [rob_pkg::credit_w-1:0] pending_d;

    // a flush frees every occupied entry at once
    always_comb begin
        if (free_many) begin
            add = free_count;
        end else if (free_one) begin
            add = 1'b1;
        end else begin
            add = '0;
        end
    end

    // one credit back per cycle
    assign credit_valid = (pending_q != '0);

    always_comb begin
        pending_d = pending_q + add;
        if (credit_valid) begin
            pending_d = pending_d - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= '0;
        end else begin
            pending_q <= pending_d;
        end
    end

    // credits held by dispatcher plus pending plus occupied stay at depth
    a_pending_bound: assert property (
        @(posedge clk) disable iff (rst)
        pending_q <= rob_pkg::rob_depth
    );

endmodule

`default_nettype wire

// File: verilog/rob_entry_table.sv
`timescale 1ns/1ps
`default_nettype none

module rob_entry_table (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         alloc_valid,
    input  isa_pkg::op_class_t           alloc_class,
    input  rob_pkg::regnm_t              alloc_rd,
    input  logic                         alloc_pred,
    output rob_pkg::tag_t                alloc_tag,
    input  logic                         cmpl_valid,
    input  rob_pkg::tag_t                cmpl_tag,
    input  logic                         cmpl_actual,
    input  logic                         retire,
    input  logic                         clear,
    output rob_pkg::tag_t                head_tag,
    output logic                         head_valid,
    output logic                         head_done,
    output logic                         head_store,
    output logic                         head_mispredict,
    output rob_pkg::regnm_t              head_rd,
    output logic [rob_pkg::credit_w-1:0] occupied_count
);

    // status bits, cleared by reset and flush
    logic [rob_pkg::rob_depth-1:0] occupied_q;
    logic [rob_pkg::rob_depth-1:0] done_q;

    // per-entry fields written at allocation or completion
    logic [rob_pkg::rob_depth-1:0] store_q;
    logic [rob_pkg::rob_depth-1:0] pred_q;
    logic [rob_pkg::rob_depth-1:0] actual_q;
    rob_pkg::regnm_t               rd_q [rob_pkg::rob_depth];

    rob_pkg::tag_t                 head_q;
    rob_pkg::tag_t                 tail_q;
    logic [rob_pkg::credit_w-1:0]  count_q;

    assign alloc_tag = tail_q;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            occupied_q <= '0;
            done_q     <= '0;
            head_q     <= '0;
            tail_q     <= '0;
        end else begin
            if (alloc_valid) begin
                occupied_q[tail_q] <= 1'b1;
                done_q[tail_q]     <= 1'b0;
                tail_q             <= tail_q + 1'b1;
            end
            if (cmpl_valid) begin
                done_q[cmpl_tag] <= 1'b1;
            end
            if (retire) begin
                occupied_q[head_q] <= 1'b0;
                head_q             <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            count_q <= '0;
        end else begin
            case ({alloc_valid, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            store_q[tail_q] <= isa_pkg::is_store_class(alloc_class);
            pred_q[tail_q]  <= alloc_pred;
            rd_q[tail_q]    <= alloc_rd;
        end
        if (cmpl_valid) begin
            actual_q[cmpl_tag] <= cmpl_actual;
        end
    end

    assign head_tag        = head_q;
    assign head_valid      = occupied_q[head_q];
    assign head_done       = done_q[head_q];
    assign head_store      = store_q[head_q];
    assign head_rd         = rd_q[head_q];
    assign head_mispredict = done_q[head_q] && (pred_q[head_q] != actual_q[head_q]);
    assign occupied_count  = count_q;

    // dispatcher must hold a credit, so the table is never full here
    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (rst)
        alloc_valid |-> (count_q != rob_pkg::rob_depth)
    );

    a_cmpl_live: assert property (
        @(posedge clk) disable iff (rst)
        cmpl_valid |-> (occupied_q[cmpl_tag] && !done_q[cmpl_tag])
    );

    // dispatcher stalls while the flush clears the table
    a_no_alloc_on_clear: assert property (
        @(posedge clk) disable iff (rst)
        clear |-> !alloc_valid
    );

endmodule

`default_nettype wire

// File: verilog/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // buffer geometry
    localparam int rob_depth = 16;
    // depth is a power of two so the pointers wrap on their own
    localparam int tag_w = $clog2(rob_depth);

    // credit count must reach rob_depth itself
    localparam int credit_w = $clog2(rob_depth + 1);

    localparam int regnm_w = 5;
    localparam int data_w  = 32;
    localparam int addr_w  = 32;

    // entry tag, handed back to the dispatcher
    typedef logic [tag_w-1:0] tag_t;

    // architectural register name
    typedef logic [regnm_w-1:0] regnm_t;

    // result word and pc
    typedef logic [data_w-1:0] data_t;
    typedef logic [addr_w-1:0] addr_t;

    // commit FSM states
    typedef enum logic [1:0] {
        st_idle       = 2'd0,
        st_store_wait = 2'd1,
        st_flush      = 2'd2
    } commit_state_t;

endpackage

`default_nettype wire

// File: verilog/rob_result_store.sv
`timescale 1ns/1ps
`default_nettype none

module rob_result_store #(
    parameter type payload_t = logic [31:0]
) (
    input  logic          clk,
    input  logic          wr_en,
    input  rob_pkg::tag_t wr_tag,
    input  payload_t      wr_payload,
    input  rob_pkg::tag_t rd_tag,
    output payload_t      rd_payload
);

    // one slot per entry, indexed by tag
    payload_t mem [rob_pkg::rob_depth];

    // written on the completion edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_tag] <= wr_payload;
        end
    end

    // head read is combinational so commit can register it directly
    assign rd_payload = mem[rd_tag];

endmodule

`default_nettype wire

// File: verilog/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top (
    input  logic               clk,
    input  logic               rst,
    // allocation
    input  logic               alloc_valid,
    input  isa_pkg::op_class_t alloc_class,
    input  rob_pkg::regnm_t    alloc_rd,
    input  logic               alloc_pred,
    output rob_pkg::tag_t      alloc_tag,
    // completion
    input  logic               cmpl_valid,
    input  rob_pkg::tag_t      cmpl_tag,
    input  rob_pkg::data_t     cmpl_data,
    input  logic               cmpl_actual,
    input  rob_pkg::addr_t     cmpl_jump_pc,
    // commit
    output logic               commit_valid,
    output rob_pkg::regnm_t    commit_rd,
    output rob_pkg::data_t     commit_data,
    output rob_pkg::tag_t      commit_tag,
    // store buffer handoff
    output logic               store_valid,
    output rob_pkg::tag_t      store_tag,
    input  logic               store_done,
    // flush
    output logic               flush,
    output rob_pkg::addr_t     redirect_pc,
    // credits
    output logic               credit_valid
);

    rob_pkg::tag_t                head_tag;
    logic                         head_valid;
    logic                         head_done;
    logic                         head_store;
    logic                         head_mispredict;
    rob_pkg::regnm_t              head_rd;
    rob_pkg::data_t               head_data;
    rob_pkg::addr_t               head_jump_pc;
    logic                         retire;
    logic                         clear;
    logic [rob_pkg::credit_w-1:0] occupied_count;

    rob_entry_table i_rob_entry_table (
        .clk             (clk),
        .rst             (rst),
        .alloc_valid     (alloc_valid),
        .alloc_class     (alloc_class),
        .alloc_rd        (alloc_rd),
        .alloc_pred      (alloc_pred),
        .alloc_tag       (alloc_tag),
        .cmpl_valid      (cmpl_valid),
        .cmpl_tag        (cmpl_tag),
        .cmpl_actual     (cmpl_actual),
        .retire          (retire),
        .clear           (clear),
        .head_tag        (head_tag),
        .head_valid      (head_valid),
        .head_done       (head_done),
        .head_store      (head_store),
        .head_mispredict (head_mispredict),
        .head_rd         (head_rd),
        .occupied_count  (occupied_count)
    );

    // results
    rob_result_store #(
        .payload_t (rob_pkg::data_t)
    ) i_data_store (
        .clk        (clk),
        .wr_en      (cmpl_valid),
        .wr_tag     (cmpl_tag),
        .wr_payload (cmpl_data),
        .rd_tag     (head_tag),
        .rd_payload (head_data)
    );

    // branch targets
    rob_result_store #(
        .payload_t (rob_pkg::addr_t)
    ) i_jump_store (
        .clk        (clk),
        .wr_en      (cmpl_valid),
        .wr_tag     (cmpl_tag),
        .wr_payload (cmpl_jump_pc),
        .rd_tag     (head_tag),
        .rd_payload (head_jump_pc)
    );

    rob_commit_fsm i_rob_commit_fsm (
        .clk             (clk),
        .rst             (rst),
        .head_valid      (head_valid),
        .head_done       (head_done),
        .head_store      (head_store),
        .head_mispredict (head_mispredict),
        .head_tag        (head_tag),
        .head_rd         (head_rd),
        .head_data       (head_data),
        .head_jump_pc    (head_jump_pc),
        .store_done      (store_done),
        .retire          (retire),
        .clear           (clear),
        .commit_valid    (commit_valid),
        .commit_rd       (commit_rd),
        .commit_data     (commit_data),
        .commit_tag      (commit_tag),
        .store_valid     (store_valid),
        .store_tag       (store_tag),
        .flush           (flush),
        .redirect_pc     (redirect_pc)
    );

    // a clear returns every occupied entry, the branch included
    rob_credit_counter i_rob_credit_counter (
        .clk          (clk),
        .rst          (rst),
        .free_one     (retire),
        .free_many    (clear),
        .free_count   (occupied_count),
        .credit_valid (credit_valid)
    );

endmodule

`default_nettype wire
